//--- accel_pkg.sv
`default_nettype none

package accel_pkg;

    // ******************************
    // fixed sram address widths
    // ******************************
    localparam int XMEM_AW = 11;
    localparam int PMEM_AW = 11;

    // output activation applied by sfp
    typedef enum logic [1:0] {
        act_none = 2'd0,
        act_relu = 2'd1
    } act_func_e;

    // operation travelling through the array with the data
    typedef enum logic [1:0] {
        op_nop     = 2'd0,
        op_load    = 2'd1,
        op_execute = 2'd2
    } mac_op_e;

    // weight register state of one tile
    typedef enum logic {
        ld_empty = 1'b0,
        ld_full  = 1'b1
    } ld_state_e;

    // ******************************
    // 64-bit instruction word, msb first
    // ******************************
    typedef struct packed {
        logic [27:0]        reserved;
        act_func_e          act_func;
        logic               passthrough;
        logic               acc;
        logic               pmem_ren;
        logic               pmem_cen_n;
        logic               pmem_wen_n;
        logic [PMEM_AW-1:0] pmem_a;
        logic               xmem_cen_n;
        logic               xmem_wen_n;
        logic [XMEM_AW-1:0] xmem_a;
        logic               ofifo_rd;
        logic               l0_rd;
        logic               l0_wr;
        logic               execute;
        logic               load;
    } core_inst_t;

endpackage

`default_nettype wire

//--- sram_if.sv
`timescale 1ns/1ns
`default_nettype none

interface sram_if #(
    parameter int WIDTH = 16,
    parameter int AW    = 11
);

    // data in and data out
    logic [WIDTH-1:0] d;
    logic [WIDTH-1:0] q;
    // word address
    logic [AW-1:0]    a;
    // active low chip and write enables
    logic             cen_n;
    logic             wen_n;
    // read enable, active high
    logic             ren;

    modport controller (output d, a, cen_n, wen_n, ren, input q);
    modport memory (input d, a, cen_n, wen_n, ren, output q);

endinterface

`default_nettype wire

//--- sram_1p.sv
`timescale 1ns/1ns
`default_nettype none

module sram_1p #(
    parameter int WIDTH    = 16,
    parameter int DEPTH_AW = 11
) (
    input wire logic clk,
    sram_if.memory   mem
);

    // storage, one word per address
    logic [WIDTH-1:0] ram [2**DEPTH_AW];

    logic do_write;
    logic do_read;

    // write when both enables low
    assign do_write = !mem.cen_n && !mem.wen_n;
    // read needs the chip selected, write off and ren high
    assign do_read  = !mem.cen_n && mem.wen_n && mem.ren;

    always_ff @(posedge clk) begin
        if (do_write) begin
            ram[mem.a] <= mem.d;
        end
    end

    // registered read, q holds until the next read
    always_ff @(posedge clk) begin
        if (do_read) begin
            mem.q <= ram[mem.a];
        end
    end

endmodule

`default_nettype wire

//--- l0_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module l0_fifo #(
    parameter int ROW        = 4,
    parameter int BW         = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              wr_i,
    input  wire logic              rd_i,
    input  wire logic [ROW*BW-1:0] data_i,
    output logic      [ROW*BW-1:0] data_o
);

    localparam int PW = $clog2(FIFO_DEPTH);

    // per-row read strobe, row 0 takes rd_i directly
    logic [ROW-1:0] row_rd;
    // rd_i delayed 1..ROW-1 cycles
    logic [ROW-1:1] rd_dly;

    assign row_rd = {rd_dly, rd_i};

    // ******************************
    // read skew shift register
    // ******************************
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_dly <= '0;
        end else begin
            rd_dly <= row_rd[ROW-2:0];
        end
    end

    // ******************************
    // one circular buffer per row
    // ******************************
    for (genvar r = 0; r < ROW; r++) begin : g_row
        logic [BW-1:0] buf_q [FIFO_DEPTH];
        // extra msb tells full from empty
        logic [PW:0]   wr_ptr;
        logic [PW:0]   rd_ptr;
        logic          empty;
        logic          full;

        assign empty = (wr_ptr == rd_ptr);
        assign full  = (wr_ptr[PW-1:0] == rd_ptr[PW-1:0]) && (wr_ptr[PW] != rd_ptr[PW]);

        always_ff @(posedge clk) begin
            if (reset) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                // writes to a full row are lost
                if (wr_i && !full) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (row_rd[r] && !empty) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (wr_i && !full) begin
                buf_q[wr_ptr[PW-1:0]] <= data_i[r*BW +: BW];
            end
        end

        // head shows only while this row pops, zeros otherwise
        assign data_o[r*BW +: BW] = (row_rd[r] && !empty) ? buf_q[rd_ptr[PW-1:0]] : '0;
    end

endmodule

`default_nettype wire

//--- mac_tile.sv
`timescale 1ns/1ns
`default_nettype none

module mac_tile #(
    parameter int BW      = 4,
    parameter int PSUM_BW = 16
) (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic [BW-1:0]      act_i,
    input  accel_pkg::mac_op_e      op_i,
    input  wire logic [PSUM_BW-1:0] psum_i,
    output logic      [BW-1:0]      act_o,
    output accel_pkg::mac_op_e      op_o,
    output logic      [PSUM_BW-1:0] psum_o,
    output logic                    valid_o
);

    accel_pkg::ld_state_e  ld_state;
    logic signed [BW-1:0]  weight_q;
    // unsigned act times signed weight
    logic signed [2*BW:0]  prod;
    logic                  capture;

    // first load after reset stays here
    assign capture = (op_i == accel_pkg::op_load) && (ld_state == accel_pkg::ld_empty);
    assign prod    = $signed({1'b0, act_i}) * weight_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            ld_state <= accel_pkg::ld_empty;
            op_o     <= accel_pkg::op_nop;
            psum_o   <= '0;
            valid_o  <= 1'b0;
        end else begin
            if (capture) begin
                ld_state <= accel_pkg::ld_full;
            end
            // captured load stops here, next tile waits for its own vector
            op_o    <= capture ? accel_pkg::op_nop : op_i;
            valid_o <= (op_i == accel_pkg::op_execute);
            if (op_i == accel_pkg::op_execute) begin
                psum_o <= psum_i + {{(PSUM_BW-2*BW-1){prod[2*BW]}}, prod};
            end
        end
    end

    // activation moves east every cycle
    always_ff @(posedge clk) begin
        act_o <= act_i;
        if (capture) begin
            weight_q <= act_i;
        end
    end

endmodule

`default_nettype wire

//--- mac_array.sv
`timescale 1ns/1ns
`default_nettype none

module mac_array #(
    parameter int ROW     = 4,
    parameter int COL     = 4,
    parameter int BW      = 4,
    parameter int PSUM_BW = 16
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [ROW*BW-1:0]      west_i,
    input  accel_pkg::mac_op_e          op_i,
    output logic      [COL*PSUM_BW-1:0] psum_o,
    output logic      [COL-1:0]         valid_o
);

    // horizontal links, index c is the input of column c
    logic [BW-1:0]      act_w [ROW][COL+1];
    accel_pkg::mac_op_e op_w  [ROW][COL+1];
    // vertical links, row 0 is the north edge, row ROW the bottom
    logic [PSUM_BW-1:0] psum_w [ROW+1][COL];
    logic [COL-1:0]     valid_w [ROW];
    // op delayed 1..ROW-1 cycles for rows 1..ROW-1
    accel_pkg::mac_op_e op_pipe [ROW-1];

    // ******************************
    // per-row op delay
    // ******************************
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < ROW-1; k++) begin
                op_pipe[k] <= accel_pkg::op_nop;
            end
        end else begin
            op_pipe[0] <= op_i;
            for (int k = 1; k < ROW-1; k++) begin
                op_pipe[k] <= op_pipe[k-1];
            end
        end
    end

    // ******************************
    // tile grid
    // ******************************
    for (genvar r = 0; r < ROW; r++) begin : g_row
        assign act_w[r][0] = west_i[r*BW +: BW];

        if (r == 0) begin : g_first
            assign op_w[r][0] = op_i;
        end else begin : g_delayed
            assign op_w[r][0] = op_pipe[r-1];
        end

        for (genvar c = 0; c < COL; c++) begin : g_col
            mac_tile #(
                .BW      (BW),
                .PSUM_BW (PSUM_BW)
            ) u_tile (
                .clk     (clk),
                .reset   (reset),
                .act_i   (act_w[r][c]),
                .op_i    (op_w[r][c]),
                .psum_i  (psum_w[r][c]),
                .act_o   (act_w[r][c+1]),
                .op_o    (op_w[r][c+1]),
                .psum_o  (psum_w[r+1][c]),
                .valid_o (valid_w[r][c])
            );
        end
    end

    // zero psum enters at the top, results leave at the bottom
    for (genvar c = 0; c < COL; c++) begin : g_edge
        assign psum_w[0][c]                = '0;
        assign psum_o[c*PSUM_BW +: PSUM_BW] = psum_w[ROW][c];
    end

    // bottom row marks finished columns
    assign valid_o = valid_w[ROW-1];

endmodule

`default_nettype wire

//--- ofifo.sv
`timescale 1ns/1ns
`default_nettype none

module ofifo #(
    parameter int COL        = 4,
    parameter int PSUM_BW    = 16,
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [COL-1:0]         wr_i,
    input  wire logic                   rd_i,
    input  wire logic [COL*PSUM_BW-1:0] data_i,
    output logic      [COL*PSUM_BW-1:0] data_o,
    output logic                        valid_o
);

    localparam int PW = $clog2(FIFO_DEPTH);

    // one read pointer for all columns
    logic [PW:0]    rd_ptr;
    logic [COL-1:0] col_valid;
    logic           pop;

    // only pop a full row of results
    assign pop     = rd_i && valid_o;
    assign valid_o = &col_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // ******************************
    // column buffers
    // ******************************
    for (genvar c = 0; c < COL; c++) begin : g_col
        logic [PSUM_BW-1:0] buf_q [FIFO_DEPTH];
        logic [PW:0]        wr_ptr;
        logic               full;

        assign col_valid[c] = (wr_ptr != rd_ptr);
        assign full = (wr_ptr[PW-1:0] == rd_ptr[PW-1:0]) && (wr_ptr[PW] != rd_ptr[PW]);

        // each column fills at its own cycle
        always_ff @(posedge clk) begin
            if (reset) begin
                wr_ptr <= '0;
            end else if (wr_i[c] && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (wr_i[c] && !full) begin
                buf_q[wr_ptr[PW-1:0]] <= data_i[c*PSUM_BW +: PSUM_BW];
            end
        end

        // head is visible without a read
        assign data_o[c*PSUM_BW +: PSUM_BW] = buf_q[rd_ptr[PW-1:0]];
    end

endmodule

`default_nettype wire

//--- sfp.sv
`timescale 1ns/1ns
`default_nettype none

module sfp #(
    parameter int PSUM_BW = 16
) (
    input  wire logic [PSUM_BW-1:0] ofifo_i,
    input  wire logic [PSUM_BW-1:0] psum_i,
    input  wire logic               acc_i,
    input  accel_pkg::act_func_e    act_func_i,
    input  wire logic               passthrough_i,
    output logic      [PSUM_BW-1:0] out_o
);

    logic [PSUM_BW-1:0] sum;

    always_comb begin
        // add stored partial sum only on accumulate passes
        if (acc_i) begin
            sum = ofifo_i + psum_i;
        end else begin
            sum = ofifo_i;
        end

        if (passthrough_i) begin
            // stored word goes out untouched
            out_o = psum_i;
        end else if (act_func_i == accel_pkg::act_relu && sum[PSUM_BW-1]) begin
            // relu, negative clamps to zero
            out_o = '0;
        end else begin
            out_o = sum;
        end
    end

endmodule

`default_nettype wire

//--- core.sv
`timescale 1ns/1ns
`default_nettype none

module core #(
    parameter int BW         = 4,
    parameter int PSUM_BW    = 16,
    parameter int ROW        = 4,
    parameter int COL        = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [63:0]            inst_i,
    input  wire logic [ROW*BW-1:0]      d_xmem_i,
    output logic                        ofifo_valid_o,
    output logic      [COL*PSUM_BW-1:0] sfp_out_o
);

    accel_pkg::core_inst_t inst;
    accel_pkg::mac_op_e    mac_op;

    // datapath between the blocks
    logic [ROW*BW-1:0]      l0_west;
    logic [COL*PSUM_BW-1:0] array_psum;
    logic [COL-1:0]         array_valid;
    logic [COL*PSUM_BW-1:0] ofifo_data;
    logic [COL*PSUM_BW-1:0] sfp_data;

    // ******************************
    // instruction decode
    // ******************************
    assign inst = accel_pkg::core_inst_t'(inst_i);

    // execute wins if both bits are set
    always_comb begin
        if (inst.execute) begin
            mac_op = accel_pkg::op_execute;
        end else if (inst.load) begin
            mac_op = accel_pkg::op_load;
        end else begin
            mac_op = accel_pkg::op_nop;
        end
    end

    // ******************************
    // srams
    // ******************************
    sram_if #(.WIDTH(ROW*BW), .AW(accel_pkg::XMEM_AW)) xmem_bus ();
    sram_if #(.WIDTH(COL*PSUM_BW), .AW(accel_pkg::PMEM_AW)) pmem_bus ();

    // activations and weights come straight from the testbench
    assign xmem_bus.d     = d_xmem_i;
    assign xmem_bus.a     = inst.xmem_a;
    assign xmem_bus.cen_n = inst.xmem_cen_n;
    assign xmem_bus.wen_n = inst.xmem_wen_n;
    // xmem reads whenever selected
    assign xmem_bus.ren   = !inst.xmem_cen_n;

    // psum store writes back what sfp produces
    assign pmem_bus.d     = sfp_data;
    assign pmem_bus.a     = inst.pmem_a;
    assign pmem_bus.cen_n = inst.pmem_cen_n;
    assign pmem_bus.wen_n = inst.pmem_wen_n;
    assign pmem_bus.ren   = inst.pmem_ren;

    sram_1p #(.WIDTH(ROW*BW), .DEPTH_AW(accel_pkg::XMEM_AW)) xmem_sram (
        .clk (clk),
        .mem (xmem_bus.memory)
    );

    sram_1p #(.WIDTH(COL*PSUM_BW), .DEPTH_AW(accel_pkg::PMEM_AW)) pmem_sram (
        .clk (clk),
        .mem (pmem_bus.memory)
    );

    // ******************************
    // fifos and array
    // ******************************
    l0_fifo #(.ROW(ROW), .BW(BW), .FIFO_DEPTH(FIFO_DEPTH)) u_l0 (
        .clk    (clk),
        .reset  (reset),
        .wr_i   (inst.l0_wr),
        .rd_i   (inst.l0_rd),
        .data_i (xmem_bus.q[ROW*BW-1:0]),
        .data_o (l0_west)
    );

    mac_array #(.ROW(ROW), .COL(COL), .BW(BW), .PSUM_BW(PSUM_BW)) u_array (
        .clk     (clk),
        .reset   (reset),
        .west_i  (l0_west),
        .op_i    (mac_op),
        .psum_o  (array_psum),
        .valid_o (array_valid)
    );

    // a column writes whenever its result lands
    ofifo #(.COL(COL), .PSUM_BW(PSUM_BW), .FIFO_DEPTH(FIFO_DEPTH)) u_ofifo (
        .clk     (clk),
        .reset   (reset),
        .wr_i    (array_valid),
        .rd_i    (inst.ofifo_rd),
        .data_i  (array_psum),
        .data_o  (ofifo_data),
        .valid_o (ofifo_valid_o)
    );

    // one sfp per column
    for (genvar c = 0; c < COL; c++) begin : g_sfp
        sfp #(.PSUM_BW(PSUM_BW)) u_sfp (
            .ofifo_i       (ofifo_data[c*PSUM_BW +: PSUM_BW]),
            .psum_i        (pmem_bus.q[c*PSUM_BW +: PSUM_BW]),
            .acc_i         (inst.acc),
            .act_func_i    (inst.act_func),
            .passthrough_i (inst.passthrough),
            .out_o         (sfp_data[c*PSUM_BW +: PSUM_BW])
        );
    end

    assign sfp_out_o = sfp_data;

endmodule

`default_nettype wire

//--- core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module core_tb;

    localparam int BW         = 4;
    localparam int PSUM_BW    = 16;
    localparam int ROW        = 4;
    localparam int COL        = 4;
    localparam int FIFO_DEPTH = 16;
    // activation vectors per pass
    localparam int NVEC       = 6;
    // run length limit, 5 tests of at most 250 cycles
    localparam int N_TESTS         = 5;
    localparam int CYCLES_PER_TEST = 250;
    localparam int CLK_NS          = 4;
    localparam int VALID_WAIT      = 4 * (ROW + COL);

    logic                        clk;
    logic                        reset;
    accel_pkg::core_inst_t       cur_inst;
    logic [ROW*BW-1:0]           d_xmem;
    logic                        ofifo_valid;
    logic [COL*PSUM_BW-1:0]      sfp_out;

    // weights, current activations, stored pass 1 results
    logic [ROW*BW-1:0]           w_vec [COL];
    logic [ROW*BW-1:0]           act_vec [NVEC];
    logic [COL*PSUM_BW-1:0]      p1_vec [NVEC];
    // expected sfp outputs in pop order
    logic [COL*PSUM_BW-1:0]      exp_q [$];

    logic [31:0] rng_state;
    int          err_count;
    int          check_count;
    int          test_count;
    int          errs_before;

    core #(
        .BW         (BW),
        .PSUM_BW    (PSUM_BW),
        .ROW        (ROW),
        .COL        (COL),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .clk           (clk),
        .reset         (reset),
        .inst_i        (cur_inst),
        .d_xmem_i      (d_xmem),
        .ofifo_valid_o (ofifo_valid),
        .sfp_out_o     (sfp_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // ******************************
    // reference model
    // ******************************
    // xorshift32
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic logic [ROW*BW-1:0] rand_vector();
        logic [31:0] r;
        r = next_rand();
        return r[ROW*BW-1:0];
    endfunction

    // unsigned activation times signed weight, summed down column col
    function automatic logic [PSUM_BW-1:0] mac_ref(input logic [ROW*BW-1:0] act, input int col);
        int sum;
        int a;
        int w;
        sum = 0;
        for (int r = 0; r < ROW; r++) begin
            a = act[r*BW +: BW];
            w = $signed(w_vec[col][r*BW +: BW]);
            sum += a * w;
        end
        return sum[PSUM_BW-1:0];
    endfunction

    function automatic logic [COL*PSUM_BW-1:0] ref_vector(input logic [ROW*BW-1:0] act);
        logic [COL*PSUM_BW-1:0] v;
        for (int c = 0; c < COL; c++) begin
            v[c*PSUM_BW +: PSUM_BW] = mac_ref(act, c);
        end
        return v;
    endfunction

    // stored psum plus new result, clamped at zero under relu
    function automatic logic [PSUM_BW-1:0] expect_word(input logic [PSUM_BW-1:0] stored,
                                                        input logic [PSUM_BW-1:0] mac,
                                                        input logic relu);
        logic signed [PSUM_BW-1:0] sum;
        sum = stored + mac;
        if (relu && sum < 0) begin
            return '0;
        end
        return sum;
    endfunction

    // ******************************
    // compare tasks
    // ******************************
    task automatic check_psum(input logic [PSUM_BW-1:0] got, input logic [PSUM_BW-1:0] exp,
                              input int col);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error @ %0t ns: column %0d psum %h, expected %h", $time, col, got, exp);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error @ %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // sample at the rising edge, before the DUT registers move
    always @(posedge clk) begin : compare_outputs
        logic [COL*PSUM_BW-1:0] exp_v;
        if (!reset && (cur_inst.ofifo_rd || cur_inst.passthrough)) begin
            if (cur_inst.ofifo_rd && !ofifo_valid) begin
                err_count++;
                $display("ofifo read issued at %0t ns while it was empty", $time);
            end
            if (exp_q.size() == 0) begin
                err_count++;
                $display("output at %0t ns with no expected vector left", $time);
            end else begin
                exp_v = exp_q.pop_front();
                for (int c = 0; c < COL; c++) begin
                    check_psum(sfp_out[c*PSUM_BW +: PSUM_BW], exp_v[c*PSUM_BW +: PSUM_BW], c);
                end
            end
        end
    end

    // ******************************
    // instruction drivers
    // ******************************
    // both srams deselected, nothing else active
    function automatic accel_pkg::core_inst_t idle_inst();
        accel_pkg::core_inst_t i;
        i = '0;
        i.pmem_cen_n = 1'b1;
        i.pmem_wen_n = 1'b1;
        i.xmem_cen_n = 1'b1;
        i.xmem_wen_n = 1'b1;
        return i;
    endfunction

    // new word on the falling edge
    task automatic issue(input accel_pkg::core_inst_t i, input logic [ROW*BW-1:0] d);
        @(negedge clk);
        cur_inst = i;
        d_xmem   = d;
    endtask

    task automatic xmem_write(input int addr, input logic [ROW*BW-1:0] d);
        accel_pkg::core_inst_t i;
        i = idle_inst();
        i.xmem_cen_n = 1'b0;
        i.xmem_wen_n = 1'b0;
        i.xmem_a     = addr[accel_pkg::XMEM_AW-1:0];
        issue(i, d);
    endtask

    // xmem read, l0 write one cycle behind it
    task automatic fill_l0(input int base, input int n);
        accel_pkg::core_inst_t i;
        int addr;
        for (int k = 0; k <= n; k++) begin
            addr = base + k;
            i = idle_inst();
            if (k < n) begin
                i.xmem_cen_n = 1'b0;
                i.xmem_a     = addr[accel_pkg::XMEM_AW-1:0];
            end
            i.l0_wr = (k > 0);
            issue(i, '0);
        end
    endtask

    // l0 pops together with load or execute
    task automatic run_array(input int n, input logic do_exec);
        accel_pkg::core_inst_t i;
        for (int k = 0; k < n; k++) begin
            i = idle_inst();
            i.l0_rd   = 1'b1;
            i.execute = do_exec;
            i.load    = !do_exec;
            issue(i, '0);
        end
        issue(idle_inst(), '0);
    endtask

    task automatic execute_pass(input int base);
        for (int k = 0; k < NVEC; k++) begin
            act_vec[k] = rand_vector();
            xmem_write(base + k, act_vec[k]);
        end
        fill_l0(base, NVEC);
        run_array(NVEC, 1'b1);
    endtask

    task automatic wait_for_valid();
        int n;
        n = 0;
        while (!ofifo_valid && n < VALID_WAIT) begin
            issue(idle_inst(), '0);
            n++;
        end
        if (!ofifo_valid) begin
            err_count++;
            $display("no ofifo output within %0d cycles at %0t ns", VALID_WAIT, $time);
        end
    endtask

    // pmem read one cycle ahead of each pop, optional store of sfp output
    task automatic drain_results(input int n, input logic read_psum, input logic store,
                                 input logic acc, input accel_pkg::act_func_e func);
        accel_pkg::core_inst_t i;
        for (int k = 0; k < n; k++) begin
            if (read_psum) begin
                i = idle_inst();
                i.pmem_cen_n = 1'b0;
                i.pmem_ren   = 1'b1;
                i.pmem_a     = k[accel_pkg::PMEM_AW-1:0];
                issue(i, '0);
            end
            wait_for_valid();
            i = idle_inst();
            i.ofifo_rd = 1'b1;
            i.acc      = acc;
            i.act_func = func;
            if (store) begin
                i.pmem_cen_n = 1'b0;
                i.pmem_wen_n = 1'b0;
                i.pmem_a     = k[accel_pkg::PMEM_AW-1:0];
            end
            issue(i, '0);
        end
        issue(idle_inst(), '0);
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name, err_count - errs_before);
        end
        errs_before = err_count;
    endtask

    // second pass over pmem, acc on
    task automatic accumulate_test(input int base, input accel_pkg::act_func_e func,
                                   input string name);
        logic [COL*PSUM_BW-1:0] mac;
        logic [COL*PSUM_BW-1:0] exp_v;
        execute_pass(base);
        for (int k = 0; k < NVEC; k++) begin
            mac = ref_vector(act_vec[k]);
            for (int c = 0; c < COL; c++) begin
                exp_v[c*PSUM_BW +: PSUM_BW] = expect_word(p1_vec[k][c*PSUM_BW +: PSUM_BW],
                                                          mac[c*PSUM_BW +: PSUM_BW],
                                                          func == accel_pkg::act_relu);
            end
            exp_q.push_back(exp_v);
        end
        drain_results(NVEC, 1'b1, 1'b0, 1'b1, func);
        check_valid(ofifo_valid, 1'b0, "ofifo valid after drain");
        end_test(name);
    endtask

    // ******************************
    // main sequence
    // ******************************
    initial begin
        accel_pkg::core_inst_t i;
        rng_state   = 32'd97396;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        errs_before = 0;
        cur_inst    = idle_inst();
        d_xmem      = '0;
        reset       = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_valid(ofifo_valid, 1'b0, "ofifo valid after reset");
        end_test("reset");

        // weights to xmem, then through l0 into the tiles
        for (int c = 0; c < COL; c++) begin
            w_vec[c] = rand_vector();
            xmem_write(c, w_vec[c]);
        end
        fill_l0(0, COL);
        run_array(COL, 1'b0);
        execute_pass(16);
        for (int k = 0; k < NVEC; k++) begin
            p1_vec[k] = ref_vector(act_vec[k]);
            exp_q.push_back(p1_vec[k]);
        end
        // pass 1 lands in pmem at address k
        drain_results(NVEC, 1'b0, 1'b1, 1'b0, accel_pkg::act_none);
        check_valid(ofifo_valid, 1'b0, "ofifo valid after drain");
        end_test("plain multiply");

        accumulate_test(32, accel_pkg::act_none, "accumulate");
        accumulate_test(48, accel_pkg::act_relu, "relu");

        // stored words straight out
        for (int k = 0; k < NVEC; k++) begin
            exp_q.push_back(p1_vec[k]);
            i = idle_inst();
            i.pmem_cen_n = 1'b0;
            i.pmem_ren   = 1'b1;
            i.pmem_a     = k[accel_pkg::PMEM_AW-1:0];
            issue(i, '0);
            i = idle_inst();
            i.passthrough = 1'b1;
            issue(i, '0);
        end
        issue(idle_inst(), '0);
        end_test("passthrough");

        if (exp_q.size() != 0) begin
            err_count++;
            $display("%0d expected vectors never came out", exp_q.size());
        end
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(N_TESTS * CYCLES_PER_TEST * CLK_NS);
        $display("timeout: run did not finish within %0d ns", N_TESTS * CYCLES_PER_TEST * CLK_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
accel_pkg.sv
sram_if.sv
sram_1p.sv
l0_fifo.sv
mac_tile.sv
mac_array.sv
ofifo.sv
sfp.sv
core.sv
core_tb.sv
